// File: design/ts_monitor_pkg.sv
package ts_monitor_pkg;

	typedef logic [31:0] axil_data_t;   // bus word and buffer word.
	typedef logic [11:0] axil_addr_t;
	typedef logic [7:0]  ts_byte_t;
	typedef logic [12:0] pid_t;
	typedef logic [7:0]  byte_idx_t;    // 0 to 187 inside a packet.
	typedef logic [5:0]  word_idx_t;    // 0 to 46 inside a packet.

	localparam int PACK_BYTES = 188;
	localparam int PACK_WORDS = 47;
	localparam ts_byte_t SYNC_BYTE = 8'h47;

	localparam int COUNT_W = 16;  // width of the captured packet counter.
	localparam int STRB_W = 4;

	localparam axil_addr_t REG_PID = 12'h000;
	localparam axil_addr_t REG_CTRL = 12'h004;
	localparam axil_addr_t REG_STATUS = 12'h008;
	localparam axil_addr_t REG_DATA_BASE = 12'h100;

	// bit positions inside the PID and control registers.
	localparam int PID_EN_BIT = 16;
	localparam int CTRL_MATCH_BIT = 0;
	localparam int CTRL_PUMP_BIT = 1;

	typedef enum logic [1:0] {IDLE, COPY, DONE} reader_state_t;
	typedef enum logic [1:0] {WR_IDLE, WR_EXEC, WR_RESP} axil_wr_state_t;
	typedef enum logic {RD_IDLE, RD_DATA} axil_rd_state_t;

endpackage

// File: design/ts_header_decoder.sv
`timescale 1ns/1ps

module ts_header_decoder import ts_monitor_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  ts_byte_t ts_data,
	input  logic     ts_valid,
	input  logic     ts_sync,
	input  pid_t     cfg_pid,
	input  logic     cfg_pid_en,
	input  logic     cfg_match_en,
	output ts_byte_t out_byte,
	output logic     out_valid,
	output logic     out_first,
	output logic     out_keep
);

	// d1 is the newest byte, d3 the oldest.
	ts_byte_t d1, d2, d3;
	logic s1, s2, s3;
	logic [2:0] fill;    // which delay line stages hold a real byte.
	pid_t hdr_pid;
	logic pkt_start;
	logic pid_match;

	assign hdr_pid = {d2[4:0], d1};
	assign pkt_start = fill[2] && s3 && (d3 == SYNC_BYTE);
	assign pid_match = cfg_pid_en && cfg_match_en && (hdr_pid == cfg_pid);

	always_ff @(posedge clk) begin
		if (ts_valid) begin
			d1 <= ts_data;
			d2 <= d1;
			d3 <= d2;
			out_byte <= d3;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1 <= 1'b0;
			s2 <= 1'b0;
			s3 <= 1'b0;
			fill <= '0;
			out_valid <= 1'b0;
			out_first <= 1'b0;
			out_keep <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			out_first <= 1'b0;
			if (ts_valid) begin
				s1 <= ts_sync;
				s2 <= s1;
				s3 <= s2;
				fill <= {fill[1:0], 1'b1};
				out_valid <= fill[2];
				out_first <= pkt_start;
				// the verdict holds until the next header has been judged.
				if (pkt_start)
					out_keep <= pid_match;
			end
		end
	end

endmodule

// File: design/ts_packet_capture.sv
`timescale 1ns/1ps

module ts_packet_capture import ts_monitor_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  ts_byte_t           in_byte,
	input  logic               in_valid,
	input  logic               in_first,
	input  logic               in_keep,
	input  word_idx_t          rd_addr,
	output axil_data_t         rd_word,
	input  logic               copy_busy,
	output logic [COUNT_W-1:0] pkt_count,
	output logic               pkt_avail
);

	axil_data_t mem [2][PACK_WORDS];

	logic fill_bank;       // bank being written, the other one is complete.
	logic active;          // a kept packet is in progress.
	logic swap_pending;
	byte_idx_t byte_cnt;
	byte_idx_t byte_sel;
	logic wr_en;
	logic last_byte;
	logic do_swap;

	assign byte_sel = in_first ? '0 : byte_cnt;
	// a new start is refused while a finished packet still waits for its swap.
	assign wr_en = in_valid && in_keep && (in_first ? !swap_pending : active);
	assign last_byte = (byte_sel == byte_idx_t'(PACK_BYTES - 1));
	assign do_swap = !copy_busy && (swap_pending || (wr_en && last_byte));

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[fill_bank][byte_sel[7:2]][8*byte_sel[1:0] +: 8] <= in_byte;
		rd_word <= mem[!fill_bank][rd_addr];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fill_bank <= 1'b0;
			active <= 1'b0;
			swap_pending <= 1'b0;
			byte_cnt <= '0;
			pkt_count <= '0;
			pkt_avail <= 1'b0;
		end else begin
			if (do_swap) begin
				fill_bank <= !fill_bank;
				swap_pending <= 1'b0;
				pkt_count <= pkt_count + 1'b1;
				pkt_avail <= 1'b1;
			end else if (wr_en && last_byte) begin
				swap_pending <= 1'b1;  // copy running, swap after it ends.
			end

			if (wr_en) begin
				active <= !last_byte;
				byte_cnt <= byte_sel + 1'b1;
			end else if (in_valid && in_first) begin
				active <= 1'b0;  // not kept, or refused.
			end
		end
	end

endmodule

// File: design/ts_packet_reader.sv
`timescale 1ns/1ps

module ts_packet_reader import ts_monitor_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       pump_req,
	input  logic       pkt_avail,
	output word_idx_t  rd_addr,
	input  axil_data_t rd_word,
	output logic       copy_busy,
	input  word_idx_t  data_rd_idx,
	output axil_data_t data_rd_word,
	output logic       done,
	output logic       busy
);

	localparam word_idx_t LAST_WORD = word_idx_t'(PACK_WORDS - 1);

	reader_state_t state;
	axil_data_t store [PACK_WORDS];
	word_idx_t addr_cnt;
	word_idx_t wr_idx;
	logic wr_vld;      // rd_word holds the word for wr_idx this cycle.
	logic store_vld;   // cleared when no packet has been captured yet.

	assign rd_addr = addr_cnt;
	assign copy_busy = (state == COPY);
	assign busy = copy_busy;
	assign done = (state == DONE);
	assign data_rd_word = (store_vld && data_rd_idx <= LAST_WORD) ? store[data_rd_idx] : '0;

	always_ff @(posedge clk) begin
		if (state == COPY && wr_vld)
			store[wr_idx] <= rd_word;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			addr_cnt <= '0;
			wr_idx <= '0;
			wr_vld <= 1'b0;
			store_vld <= 1'b0;
		end else begin
			case (state)
				IDLE, DONE: begin
					if (pump_req) begin
						addr_cnt <= '0;
						wr_vld <= 1'b0;
						store_vld <= pkt_avail;
						state <= pkt_avail ? COPY : DONE;
					end
				end
				COPY: begin
					if (wr_vld && wr_idx == LAST_WORD) begin
						wr_vld <= 1'b0;
						state <= DONE;
					end else begin
						wr_vld <= 1'b1;
						wr_idx <= addr_cnt;
						if (addr_cnt != LAST_WORD)
							addr_cnt <= addr_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: design/ts_axil_regs.sv
`timescale 1ns/1ps

module ts_axil_regs import ts_monitor_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  axil_addr_t         awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  axil_data_t         wdata,
	input  logic [STRB_W-1:0]  wstrb,
	input  logic               wvalid,
	output logic               wready,
	output logic [1:0]         bresp,
	output logic               bvalid,
	input  logic               bready,
	input  axil_addr_t         araddr,
	input  logic               arvalid,
	output logic               arready,
	output axil_data_t         rdata,
	output logic [1:0]         rresp,
	output logic               rvalid,
	input  logic               rready,
	output pid_t               cfg_pid,
	output logic               cfg_pid_en,
	output logic               cfg_match_en,
	output logic               pump_req,
	output word_idx_t          data_rd_idx,
	input  axil_data_t         data_rd_word,
	input  logic               rd_done,
	input  logic               rd_busy,
	input  logic [COUNT_W-1:0] pkt_count
);

	axil_wr_state_t wr_state;
	axil_rd_state_t rd_state;
	logic aw_got, w_got;
	logic aw_hs, w_hs;
	axil_addr_t awaddr_q;
	axil_data_t wdata_q;
	logic [STRB_W-1:0] wstrb_q;
	axil_data_t wmask;
	axil_data_t pid_word, ctrl_word, status_word, pid_new;
	logic in_window;

	assign awready = (wr_state == WR_IDLE) && !aw_got;
	assign wready = (wr_state == WR_IDLE) && !w_got;
	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign bvalid = (wr_state == WR_RESP);
	assign bresp = 2'b00;
	assign arready = (rd_state == RD_IDLE);
	assign rvalid = (rd_state == RD_DATA);
	assign rresp = 2'b00;

	always_comb begin
		for (int i = 0; i < STRB_W; i++)
			wmask[8*i +: 8] = {8{wstrb_q[i]}};
	end

	assign pid_word = {15'd0, cfg_pid_en, 3'd0, cfg_pid};
	assign ctrl_word = {31'd0, cfg_match_en};  // the readout request reads back 0.
	assign status_word = {pkt_count, 14'd0, rd_busy, rd_done};
	assign pid_new = (pid_word & ~wmask) | (wdata_q & wmask);

	// the data window starts at 0x100 and holds one packet.
	assign data_rd_idx = araddr[7:2];
	assign in_window = (araddr[11:8] == REG_DATA_BASE[11:8]) &&
		(araddr[7:2] < word_idx_t'(PACK_WORDS));

	always_ff @(posedge clk) begin
		if (aw_hs)
			awaddr_q <= awaddr;
		if (w_hs) begin
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_state <= WR_IDLE;
			aw_got <= 1'b0;
			w_got <= 1'b0;
			cfg_pid <= '0;
			cfg_pid_en <= 1'b0;
			cfg_match_en <= 1'b0;
			pump_req <= 1'b0;
		end else begin
			pump_req <= 1'b0;
			case (wr_state)
				WR_IDLE: begin
					if (aw_hs)
						aw_got <= 1'b1;
					if (w_hs)
						w_got <= 1'b1;
					if ((aw_got || aw_hs) && (w_got || w_hs))
						wr_state <= WR_EXEC;
				end
				WR_EXEC: begin
					aw_got <= 1'b0;
					w_got <= 1'b0;
					if (awaddr_q[11:2] == REG_PID[11:2]) begin
						cfg_pid <= pid_new[12:0];
						cfg_pid_en <= pid_new[PID_EN_BIT];
					end else if (awaddr_q[11:2] == REG_CTRL[11:2] && wstrb_q[0]) begin
						cfg_match_en <= wdata_q[CTRL_MATCH_BIT];
						pump_req <= wdata_q[CTRL_PUMP_BIT];
					end
					wr_state <= WR_RESP;
				end
				WR_RESP: begin
					if (bready)
						wr_state <= WR_IDLE;
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			if (araddr[11:2] == REG_PID[11:2])
				rdata <= pid_word;
			else if (araddr[11:2] == REG_CTRL[11:2])
				rdata <= ctrl_word;
			else if (araddr[11:2] == REG_STATUS[11:2])
				rdata <= status_word;
			else if (in_window)
				rdata <= data_rd_word;
			else
				rdata <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_state <= RD_IDLE;
		else if (rd_state == RD_IDLE && arvalid)
			rd_state <= RD_DATA;
		else if (rd_state == RD_DATA && rready)
			rd_state <= RD_IDLE;
	end

endmodule

// File: design/ts_monitor_top.sv
`timescale 1ns/1ps

module ts_monitor_top import ts_monitor_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  axil_addr_t        awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  axil_data_t        wdata,
	input  logic [STRB_W-1:0] wstrb,
	input  logic              wvalid,
	output logic              wready,
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready,
	input  axil_addr_t        araddr,
	input  logic              arvalid,
	output logic              arready,
	output axil_data_t        rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready,
	input  ts_byte_t          ts_data,
	input  logic              ts_valid,
	input  logic              ts_sync
);

	pid_t cfg_pid;
	logic cfg_pid_en, cfg_match_en, pump_req;
	word_idx_t data_rd_idx, rd_addr;
	axil_data_t data_rd_word, rd_word;
	logic rd_done, rd_busy, copy_busy, pkt_avail;
	logic [COUNT_W-1:0] pkt_count;
	ts_byte_t dec_byte;
	logic dec_valid, dec_first, dec_keep;

	ts_axil_regs u_regs (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.cfg_pid, .cfg_pid_en, .cfg_match_en, .pump_req,
		.data_rd_idx, .data_rd_word, .rd_done, .rd_busy, .pkt_count
	);

	ts_header_decoder u_decoder (
		.clk, .rst_n, .ts_data, .ts_valid, .ts_sync,
		.cfg_pid, .cfg_pid_en, .cfg_match_en,
		.out_byte(dec_byte), .out_valid(dec_valid),
		.out_first(dec_first), .out_keep(dec_keep)
	);

	ts_packet_capture u_capture (
		.clk, .rst_n,
		.in_byte(dec_byte), .in_valid(dec_valid),
		.in_first(dec_first), .in_keep(dec_keep),
		.rd_addr, .rd_word, .copy_busy, .pkt_count, .pkt_avail
	);

	ts_packet_reader u_reader (
		.clk, .rst_n, .pump_req, .pkt_avail, .rd_addr, .rd_word, .copy_busy,
		.data_rd_idx, .data_rd_word, .done(rd_done), .busy(rd_busy)
	);

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period.
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: testbench/ts_monitor_sva.sv
`timescale 1ns/1ps

module ts_monitor_sva import ts_monitor_pkg::*; (
	input logic          clk,
	input logic          rst_n,
	input logic          copy_busy,
	input logic          fill_bank,
	input logic          pump_req,
	input logic          done,
	input reader_state_t state,
	input word_idx_t     rd_addr
);

	// the complete bank must not change under a running copy.
	assert property (@(posedge clk) disable iff (!rst_n) copy_busy |=> $stable(fill_bank))
		else $error("bank swapped while copy_busy was high");

	// done rises at the end of a copy or straight after a request with no packet.
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(done) |-> $past(state) == COPY || $past(pump_req))
		else $error("done raised without a finished copy or a request");

	assert property (@(posedge clk) disable iff (!rst_n) done && !pump_req |=> done)
		else $error("done dropped without a new readout request");

	assert property (@(posedge clk) disable iff (!rst_n) rd_addr < word_idx_t'(PACK_WORDS))
		else $error("rd_addr beyond the last packet word");

endmodule

bind ts_packet_capture ts_monitor_sva capture_sva (
	.clk, .rst_n, .copy_busy, .fill_bank, .pump_req(1'b0), .done(1'b0),
	.state(ts_monitor_pkg::IDLE), .rd_addr
);

bind ts_packet_reader ts_monitor_sva reader_sva (
	.clk, .rst_n, .copy_busy, .fill_bank(1'b0), .pump_req, .done, .state, .rd_addr
);

// File: testbench/tb_ts_monitor.sv
`timescale 1ns/1ps

module tb_ts_monitor import ts_monitor_pkg::*; ();

	localparam int STEP_FIELDS = 9;
	localparam int TIMEOUT = 400;

	logic clk, rst_n;
	axil_addr_t awaddr, araddr;
	axil_data_t wdata, rdata;
	logic [STRB_W-1:0] wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [1:0] bresp, rresp;
	ts_byte_t ts_data;
	logic ts_valid, ts_sync;

	logic [31:0] pat [0:STEP_FIELDS*16-1];
	logic [31:0] rng;
	ts_byte_t cur_pkt [PACK_BYTES];
	ts_byte_t last_pkt [PACK_BYTES];  // last packet that matched.
	ts_byte_t old_pkt [PACK_BYTES];
	axil_data_t got [PACK_WORDS];
	int bytes_sent;
	logic [COUNT_W-1:0] exp_count;
	pid_t cfg_pid;
	logic cfg_pid_en, cfg_match;

	tb_clock_gen u_clk (.clk, .rst_n);

	ts_monitor_top i_ts_monitor_top (.*);

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic stop_with(input string msg);
		$display("Test failed");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_word(input string name, input axil_data_t act, input axil_data_t exp);
		if (act !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
			stop_with("data mismatch");
		end
	endtask

	task automatic check_pid(input string name, input pid_t act, input pid_t exp);
		if (act !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, act, exp);
			stop_with("pid mismatch");
		end
	endtask

	task automatic check_count(input string name, input logic [COUNT_W-1:0] act,
			input logic [COUNT_W-1:0] exp);
		if (act !== exp) begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, act, exp);
			stop_with("count mismatch");
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] act, input logic [1:0] exp);
		if (act !== exp) begin
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, act, exp);
			stop_with("bus response mismatch");
		end
	endtask

	task automatic axi_write(input axil_addr_t addr, input axil_data_t data);
		logic aw_done, w_done, a_hs, d_hs;
		int guard;
		aw_done = 1'b0;
		w_done = 1'b0;
		guard = 0;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= '1;
		wvalid <= 1'b1;
		bready <= 1'b1;
		while (!(aw_done && w_done)) begin
			@(negedge clk);
			a_hs = awvalid && awready;
			d_hs = wvalid && wready;
			@(posedge clk);
			if (a_hs) begin
				awvalid <= 1'b0;
				aw_done = 1'b1;
			end
			if (d_hs) begin
				wvalid <= 1'b0;
				w_done = 1'b1;
			end
			if (++guard > TIMEOUT)
				stop_with("write address or data was never accepted");
		end
		guard = 0;
		@(negedge clk);
		while (!bvalid) begin
			@(negedge clk);
			if (++guard > TIMEOUT)
				stop_with("no write response arrived");
		end
		check_resp("bresp", bresp, 2'b00);
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input axil_addr_t addr, output axil_data_t data);
		int guard;
		guard = 0;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b1;
		@(negedge clk);
		while (!arready) begin
			@(negedge clk);
			if (++guard > TIMEOUT)
				stop_with("read address was never accepted");
		end
		@(posedge clk);
		arvalid <= 1'b0;
		guard = 0;
		@(negedge clk);
		while (!rvalid) begin
			@(negedge clk);
			if (++guard > TIMEOUT)
				stop_with("no read data arrived");
		end
		data = rdata;
		check_resp("rresp", rresp, 2'b00);
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// ts_valid drops at random so the pipeline has to pause.
	task automatic send_packet(input pid_t pid);
		logic [31:0] r;
		bytes_sent = 0;
		cur_pkt[0] = SYNC_BYTE;
		cur_pkt[1] = {3'b010, pid[12:8]};
		cur_pkt[2] = pid[7:0];
		cur_pkt[3] = 8'h10;
		for (int k = 4; k < PACK_BYTES; k++) begin
			r = xorshift();
			cur_pkt[k] = r[7:0];
		end
		for (int k = 0; k < PACK_BYTES; k++) begin
			@(posedge clk);
			r = xorshift();
			while (r[2:0] == 3'd0) begin
				ts_valid <= 1'b0;
				@(posedge clk);
				r = xorshift();
			end
			ts_data <= cur_pkt[k];
			ts_valid <= 1'b1;
			ts_sync <= (k == 0);
			bytes_sent = k + 1;
		end
		@(posedge clk);
		ts_valid <= 1'b0;
		ts_sync <= 1'b0;
		if (cfg_pid_en && cfg_match && pid == cfg_pid) begin
			last_pkt = cur_pkt;
			exp_count++;
		end
	endtask

	// pushes the last bytes out of the decoder delay line.
	task automatic flush_stream();
		repeat (4) begin
			@(posedge clk);
			ts_data <= 8'hff;
			ts_valid <= 1'b1;
			ts_sync <= 1'b0;
		end
		@(posedge clk);
		ts_valid <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic wait_sent(input int n);
		int guard;
		guard = 0;
		while (bytes_sent < n) begin
			@(negedge clk);
			if (++guard > 4 * TIMEOUT)
				stop_with("stream did not reach the readout point");
		end
	endtask

	task automatic wait_done();
		axil_data_t st;
		int guard;
		guard = 0;
		axi_read(REG_STATUS, st);
		while (!st[0]) begin
			axi_read(REG_STATUS, st);
			if (++guard > TIMEOUT)
				stop_with("readout never finished");
		end
	endtask

	function automatic axil_data_t expected_word(input bit use_old, input int i);
		if (use_old)
			return {old_pkt[4*i+3], old_pkt[4*i+2], old_pkt[4*i+1], old_pkt[4*i]};
		return {last_pkt[4*i+3], last_pkt[4*i+2], last_pkt[4*i+1], last_pkt[4*i]};
	endfunction

	task automatic read_packet();
		for (int i = 0; i < PACK_WORDS; i++)
			axi_read(REG_DATA_BASE + axil_addr_t'(4 * i), got[i]);
	endtask

	// a readout during arrival may return the old or the new packet but never a mix.
	task automatic compare_packet(input bit allow_old);
		bit same_new;
		same_new = 1'b1;
		for (int i = 0; i < PACK_WORDS; i++)
			if (got[i] !== expected_word(1'b0, i))
				same_new = 1'b0;
		for (int i = 0; i < PACK_WORDS; i++)
			if (!same_new || !allow_old)
				check_word($sformatf("data[%0d]", i), got[i], expected_word(allow_old, i));
	endtask

	initial begin
		axil_data_t r;
		logic [31:0] pid_reg;
		int n, base;
		logic rd_after, mid;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		ts_data = '0;
		ts_valid = 1'b0;
		ts_sync = 1'b0;
		rng = 32'h1d2af118;
		exp_count = '0;
		bytes_sent = 0;
		for (int k = 0; k < PACK_BYTES; k++)
			last_pkt[k] = 8'h00;  // the store reads zero before any capture.
		$readmemh("testbench/ts_patterns.txt", pat);

		n = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			if (++n > 100)
				stop_with("reset never released");
		end
		repeat (2) @(posedge clk);

		axi_read(REG_PID, r);
		check_word("pid_reg", r, '0);
		axi_read(REG_CTRL, r);
		check_word("ctrl_reg", r, '0);
		axi_read(REG_STATUS, r);
		check_word("status_reg", r, '0);

		axi_write(REG_PID, 32'hffff_ffff);
		axi_read(REG_PID, r);
		check_word("pid_reg", r, 32'h0001_1fff);
		check_pid("pid_field", r[12:0], 13'h1fff);
		axi_read(12'h00c, r);
		check_word("unmapped", r, '0);

		// a readout before any capture finds an empty store.
		axi_write(REG_CTRL, 32'h0000_0002);
		wait_done();
		read_packet();
		compare_packet(1'b0);

		for (int s = 0; s < 16; s++) begin
			base = s * STEP_FIELDS;
			pid_reg = pat[base];
			if (pid_reg === 32'hffff_ffff)
				break;
			cfg_pid = pid_reg[12:0];
			cfg_pid_en = pid_reg[PID_EN_BIT];
			cfg_match = pat[base+1][0];
			n = pat[base+2];
			rd_after = pat[base+7][0];
			mid = pat[base+8][0];
			axi_write(REG_PID, pid_reg);
			axi_write(REG_CTRL, {31'd0, cfg_match});
			for (int j = 0; j < n; j++) begin
				if (mid && j == n - 1) begin
					old_pkt = last_pkt;
					fork
						send_packet(pid_t'(pat[base+3+j]));
						begin
							// late enough that the last byte lands during the copy.
							wait_sent(180);
							axi_write(REG_CTRL, {30'd0, 1'b1, cfg_match});
						end
					join
				end else begin
					send_packet(pid_t'(pat[base+3+j]));
				end
			end
			flush_stream();
			if (mid) begin
				wait_done();
				read_packet();
				compare_packet(1'b1);
			end
			if (rd_after) begin
				axi_write(REG_CTRL, {30'd0, 1'b1, cfg_match});
				wait_done();
				read_packet();
				compare_packet(1'b0);
			end
			axi_read(REG_STATUS, r);
			check_count("pkt_count", r[31:16], exp_count);
		end

		$display("Test passed");
		$finish;
	end

endmodule

// File: testbench/ts_patterns.txt
// pid_reg match_en count pid0 pid1 pid2 pid3 readout mid_readout
// a step ends the list when pid_reg is ffffffff
00010100 1 2 0100 0100 0000 0000 1 0
00010100 1 3 0021 0100 0022 0000 1 0
00000100 1 2 0100 0100 0000 0000 1 0
00010100 0 1 0100 0000 0000 0000 1 0
00011abc 1 2 1abc 0100 0000 0000 1 0
00010100 1 3 0021 1abc 0033 0000 1 0
00010100 1 2 0100 0100 0000 0000 0 1
00011abc 1 1 1abc 0000 0000 0000 0 1
ffffffff 0 0 0000 0000 0000 0000 0 0

// File: build.f
design/ts_monitor_pkg.sv
design/ts_header_decoder.sv
design/ts_packet_capture.sv
design/ts_packet_reader.sv
design/ts_axil_regs.sv
design/ts_monitor_top.sv
testbench/tb_clock_gen.sv
testbench/ts_monitor_sva.sv
testbench/tb_ts_monitor.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TS monitor testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_ts_monitor -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile step returned an error"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation returned an error, see sim.log"
	exit 1
fi

if grep -q "^Test passed$" sim.log; then
	exit 0
fi
echo "pass message missing from sim.log"
exit 1
